//--- hdl/spectral_pkg.sv
// sample format and buffer geometry shared by every block
// buf_depth and group_size must be powers of two so indices wrap by themselves
// samples and gains are signed q15 words

`default_nettype none

package spectral_pkg;

    // one audio sample, the scale gain uses the same q15 format
    localparam int sample_w = 16;

    // shared sample buffer
    localparam int buf_depth = 64;
    localparam int addr_w = $clog2(buf_depth);

    // a scale command covers group_size adjacent bins
    localparam int group_size = 4;
    // group number is the upper part of a buffer index
    localparam int group_w = addr_w - $clog2(group_size);

    typedef logic signed [sample_w-1:0] sample_t;
    typedef logic [addr_w-1:0] addr_t;

endpackage

`default_nettype wire

//--- hdl/buffer_bus_pkg.sv
// request and response formats of the shared buffer bus
// a peer holds its request until grant; read data is valid the cycle after grant
// lower peer index wins arbitration

`default_nettype none

package buffer_bus_pkg;

    localparam int num_peers = 3;

    // peer numbering, also the priority order
    localparam int peer_capture = 0;
    localparam int peer_scaler = 1;
    localparam int peer_player = 2;

    // 24 bits from a peer to the arbiter
    typedef struct packed {
        logic req;
        logic wr;
        spectral_pkg::addr_t addr;
        spectral_pkg::sample_t wdata;
    } buf_req_t;

    // 17 bits back, rdata is the shared memory output
    typedef struct packed {
        logic gnt;
        spectral_pkg::sample_t rdata;
    } buf_rsp_t;

endpackage

`default_nettype wire

//--- hdl/sample_capture.sv
// adc sample capture into the shared buffer, written circularly from index 0
// adc_ready edges must be at least three clocks apart
// a sample reaches memory two clocks after its edge is seen

`timescale 1ns/1ps
`default_nettype none

module sample_capture (
    input  logic                     clock,
    input  logic                     fft_reset,
    input  logic                     adc_ready,
    input  spectral_pkg::sample_t    adc_sample,
    output buffer_bus_pkg::buf_req_t buf_req,
    input  buffer_bus_pkg::buf_rsp_t buf_rsp
);
    import spectral_pkg::*;

    logic    adc_q;
    logic    adc_edge;
    logic    pend;
    sample_t sample_q;
    addr_t   wr_ptr;

    // rising level against the registered copy
    assign adc_edge = adc_ready & ~adc_q;

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            adc_q <= 1'b0;
            pend <= 1'b0;
            wr_ptr <= '0;
        end else begin
            adc_q <= adc_ready;
            if (adc_edge) begin
                pend <= 1'b1;
            end else if (buf_rsp.gnt) begin
                pend <= 1'b0;
            end
            // pointer moves once the word is actually written
            if (buf_rsp.gnt) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // sample latched in the edge cycle
    always_ff @(posedge clock) begin
        if (adc_edge) begin
            sample_q <= adc_sample;
        end
    end

    // top priority, so a pending write is granted right away
    assign buf_req.req = pend;
    assign buf_req.wr = 1'b1;
    assign buf_req.addr = wr_ptr;
    assign buf_req.wdata = sample_q;

    // only one sample is held, a second edge would overwrite it before the write
    assert property (@(posedge clock) disable iff (fft_reset) pend |-> !adc_edge)
        else $error("adc edge while previous sample still pending");

endmodule

`default_nettype wire

//--- hdl/bin_scaler.sv
// q15 gain applied to one group of four adjacent buffer words
// each word is read, scaled and written back before the next one
// a start while busy is ignored; latency grows when higher peers take the bus

`timescale 1ns/1ps
`default_nettype none

module bin_scaler (
    input  logic                        clock,
    input  logic                        fft_reset,
    input  logic                        scale_start,
    input  logic [spectral_pkg::group_w-1:0] scale_group,
    input  spectral_pkg::sample_t       scale_gain,
    output logic                        scale_busy,
    output buffer_bus_pkg::buf_req_t    buf_req,
    input  buffer_bus_pkg::buf_rsp_t    buf_rsp
);
    import spectral_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_wait_data,
        st_write
    } scale_state_t;

    scale_state_t                state;
    logic [addr_w-group_w-1:0]   bin_q;
    logic [group_w-1:0]          group_q;
    addr_t                       addr_q;
    sample_t                     gain_q;
    sample_t                     result_q;
    logic signed [2*sample_w-1:0] product;
    logic                        start_ok;

    assign start_ok = scale_start && (state == st_idle);
    assign scale_busy = (state != st_idle);

    // full precision product of gain and the word just read
    assign product = gain_q * $signed(buf_rsp.rdata);

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            state <= st_idle;
            bin_q <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start_ok) begin
                        state <= st_read;
                    end
                end
                st_read: begin
                    if (buf_rsp.gnt) begin
                        state <= st_wait_data;
                    end
                end
                // rdata is valid only in this cycle
                st_wait_data: begin
                    state <= st_write;
                end
                st_write: begin
                    if (buf_rsp.gnt) begin
                        // counter wraps back to 0 after the last bin
                        bin_q <= bin_q + 1'b1;
                        state <= (bin_q == group_size - 1) ? st_idle : st_read;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start_ok) begin
            group_q <= scale_group;
            gain_q <= scale_gain;
            // first bin of the group
            addr_q <= {scale_group, {(addr_w - group_w){1'b0}}};
        end else if ((state == st_write) && buf_rsp.gnt) begin
            addr_q <= addr_q + 1'b1;
        end
        // doubled high half, low bit zero, truncated to a sample
        if (state == st_wait_data) begin
            result_q <= {product[2*sample_w-2:sample_w], 1'b0};
        end
    end

    // read then write on the same index, held until granted
    assign buf_req.req = (state == st_read) || (state == st_write);
    assign buf_req.wr = (state == st_write);
    assign buf_req.addr = addr_q;
    assign buf_req.wdata = result_q;

    // running address never leaves the latched group and tracks the bin counter
    assert property (@(posedge clock) disable iff (fft_reset)
        buf_req.req |-> (addr_q[addr_w-1 -: group_w] == group_q)
                        && (addr_q[addr_w-group_w-1:0] == bin_q))
        else $error("scaler address outside latched group");

endmodule

`default_nettype wire

//--- hdl/audio_player.sv
// reads one buffer word on command and presents it on audio_out
// audio_valid is a one-cycle pulse and ends the command
// audio_out holds its last value between pulses; a start while busy is ignored

`timescale 1ns/1ps
`default_nettype none

module audio_player (
    input  logic                     clock,
    input  logic                     fft_reset,
    input  logic                     play_start,
    input  spectral_pkg::addr_t      play_index,
    output logic                     play_busy,
    output spectral_pkg::sample_t    audio_out,
    output logic                     audio_valid,
    output buffer_bus_pkg::buf_req_t buf_req,
    input  buffer_bus_pkg::buf_rsp_t buf_rsp
);
    import spectral_pkg::*;

    typedef enum logic [1:0] {
        pl_idle,
        pl_request,
        pl_fetch
    } play_state_t;

    play_state_t state;
    addr_t       index_q;

    assign play_busy = (state != pl_idle);

    always_ff @(posedge clock or posedge fft_reset) begin
        if (fft_reset) begin
            state <= pl_idle;
            audio_valid <= 1'b0;
        end else begin
            // pulse follows the cycle where rdata is valid
            audio_valid <= (state == pl_fetch);
            case (state)
                pl_idle: begin
                    if (play_start) begin
                        state <= pl_request;
                    end
                end
                // lowest priority, may wait several cycles here
                pl_request: begin
                    if (buf_rsp.gnt) begin
                        state <= pl_fetch;
                    end
                end
                default: begin
                    state <= pl_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (play_start && (state == pl_idle)) begin
            index_q <= play_index;
        end
        if (state == pl_fetch) begin
            audio_out <= buf_rsp.rdata;
        end
    end

    // read only
    assign buf_req.req = (state == pl_request);
    assign buf_req.wr = 1'b0;
    assign buf_req.addr = index_q;
    assign buf_req.wdata = '0;

endmodule

`default_nettype wire

//--- hdl/buffer_arbiter.sv
// fixed-priority arbiter in front of the 64-word sample memory
// one access per cycle, the lowest requesting peer index wins
// read data is registered and shared by all peers, valid the cycle after grant
// memory contents are undefined until written

`timescale 1ns/1ps
`default_nettype none

module buffer_arbiter (
    input  logic                     clock,
    input  logic                     fft_reset,
    input  buffer_bus_pkg::buf_req_t peer_req [buffer_bus_pkg::num_peers],
    output buffer_bus_pkg::buf_rsp_t peer_rsp [buffer_bus_pkg::num_peers]
);
    import spectral_pkg::*;
    import buffer_bus_pkg::*;

    sample_t              mem [buf_depth];
    sample_t              rdata_q;
    logic [num_peers-1:0] req_vec;
    logic [num_peers-1:0] gnt;
    buf_req_t             sel;

    // first requester from index 0 upward takes the bus
    always_comb begin
        logic found;
        found = 1'b0;
        gnt = '0;
        sel = '0;
        for (int i = 0; i < num_peers; i++) begin
            req_vec[i] = peer_req[i].req;
            if (peer_req[i].req && !found) begin
                gnt[i] = 1'b1;
                sel = peer_req[i];
                found = 1'b1;
            end
        end
    end

    // single port memory, write or read of the granted request
    always_ff @(posedge clock) begin
        if (sel.req && sel.wr) begin
            mem[sel.addr] <= sel.wdata;
        end else if (sel.req) begin
            rdata_q <= mem[sel.addr];
        end
    end

    // every peer sees its own grant and the common read data
    for (genvar p = 0; p < num_peers; p++) begin : g_rsp
        assign peer_rsp[p].gnt = gnt[p];
        assign peer_rsp[p].rdata = rdata_q;
    end

    // peers rely on never sharing a memory cycle
    assert property (@(posedge clock) disable iff (fft_reset) $onehot0(gnt))
        else $error("more than one buffer grant");

    // a grant without a request would advance a peer that did not ask
    assert property (@(posedge clock) disable iff (fft_reset) (gnt & ~req_vec) == '0)
        else $error("buffer grant to idle peer");

endmodule

`default_nettype wire

//--- hdl/spectral_buffer_top.sv
// shared spectral sample buffer with capture, scaling and playout peers
// adc_ready edges must be at least three clocks apart
// scale_start and play_start are ignored while the same peer is busy
// buffer contents are undefined until written after reset

`timescale 1ns/1ps
`default_nettype none

module spectral_buffer_top (
    input  logic                             clock,
    input  logic                             fft_reset,
    input  logic                             adc_ready,
    input  spectral_pkg::sample_t            adc_sample,
    input  logic                             scale_start,
    input  logic [spectral_pkg::group_w-1:0] scale_group,
    input  spectral_pkg::sample_t            scale_gain,
    output logic                             scale_busy,
    input  logic                             play_start,
    input  spectral_pkg::addr_t              play_index,
    output logic                             play_busy,
    output spectral_pkg::sample_t            audio_out,
    output logic                             audio_valid
);
    import buffer_bus_pkg::*;

    // one request and one response per peer, indexed by priority
    buf_req_t peer_req [num_peers];
    buf_rsp_t peer_rsp [num_peers];

    // highest priority, never waits
    sample_capture u_capture (
        .clock      (clock),
        .fft_reset  (fft_reset),
        .adc_ready  (adc_ready),
        .adc_sample (adc_sample),
        .buf_req    (peer_req[peer_capture]),
        .buf_rsp    (peer_rsp[peer_capture])
    );

    bin_scaler u_scaler (
        .clock       (clock),
        .fft_reset   (fft_reset),
        .scale_start (scale_start),
        .scale_group (scale_group),
        .scale_gain  (scale_gain),
        .scale_busy  (scale_busy),
        .buf_req     (peer_req[peer_scaler]),
        .buf_rsp     (peer_rsp[peer_scaler])
    );

    audio_player u_player (
        .clock       (clock),
        .fft_reset   (fft_reset),
        .play_start  (play_start),
        .play_index  (play_index),
        .play_busy   (play_busy),
        .audio_out   (audio_out),
        .audio_valid (audio_valid),
        .buf_req     (peer_req[peer_player]),
        .buf_rsp     (peer_rsp[peer_player])
    );

    buffer_arbiter u_arbiter (
        .clock     (clock),
        .fft_reset (fft_reset),
        .peer_req  (peer_req),
        .peer_rsp  (peer_rsp)
    );

endmodule

`default_nettype wire

//--- dv/tb_spectral_buffer.sv
// testbench for the shared spectral buffer
// the reference memory follows the capture and scale rules; buffer words start undefined
// every play records the expected word when it is accepted, the checker pops it per pulse
// adc edges are driven three clocks apart, the minimum the capture peer allows

`timescale 1ns/1ps
`default_nettype none

module tb_spectral_buffer;
    import spectral_pkg::*;

    // cycles any single wait may take before the run is abandoned
    localparam int wait_limit = 400;

    logic               clock;
    logic               fft_reset;
    logic               adc_ready;
    sample_t            adc_sample;
    logic               scale_start;
    logic [group_w-1:0] scale_group;
    sample_t            scale_gain;
    logic               scale_busy;
    logic               play_start;
    addr_t              play_index;
    logic               play_busy;
    sample_t            audio_out;
    logic               audio_valid;

    // model of the buffer and the words still owed by the player
    sample_t ref_mem [buf_depth];
    sample_t exp_q [$];
    int      cap_count = 0;
    int      plays_accepted = 0;
    int      pulses_seen = 0;
    int      errors = 0;
    string   test_name = "reset";

    spectral_buffer_top u_dut (
        .clock       (clock),
        .fft_reset   (fft_reset),
        .adc_ready   (adc_ready),
        .adc_sample  (adc_sample),
        .scale_start (scale_start),
        .scale_group (scale_group),
        .scale_gain  (scale_gain),
        .scale_busy  (scale_busy),
        .play_start  (play_start),
        .play_index  (play_index),
        .play_busy   (play_busy),
        .audio_out   (audio_out),
        .audio_valid (audio_valid)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %h actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("closing report: %0d error(s), %0d audio words checked", errors, pulses_seen);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout in test %s: %s did not happen in time", test_name, what);
        errors++;
        finish_run();
    endtask

    // q15 gain: upper half of the full product, doubled, kept to one sample
    function automatic sample_t q15_scale(input sample_t word, input sample_t gain);
        logic signed [31:0] full;
        logic [15:0]        upper;
        full = word * gain;
        upper = full[31:16];
        return sample_t'(upper << 1);
    endfunction

    // one adc_ready pulse, next edge three clocks later
    task automatic capture_sample(input sample_t value);
        @(posedge clock);
        adc_ready <= 1'b1;
        adc_sample <= value;
        ref_mem[cap_count % buf_depth] = value;
        cap_count++;
        @(posedge clock);
        adc_ready <= 1'b0;
        @(posedge clock);
    endtask

    task automatic wait_plays_done();
        int n;
        n = 0;
        @(negedge clock);
        while (pulses_seen != plays_accepted) begin
            n++;
            if (n > wait_limit) begin
                report_timeout("audio_valid pulse");
            end
            @(negedge clock);
        end
    endtask

    task automatic wait_scale_idle();
        int n;
        n = 0;
        @(negedge clock);
        while (scale_busy) begin
            n++;
            if (n > wait_limit) begin
                report_timeout("scale_busy falling");
            end
            @(negedge clock);
        end
    endtask

    // with again set, start stays high one more cycle with another index
    task automatic play_word(input addr_t idx, input bit again);
        @(posedge clock);
        play_start <= 1'b1;
        play_index <= idx;
        exp_q.push_back(ref_mem[idx]);
        plays_accepted++;
        if (again) begin
            @(posedge clock);
            play_index <= idx + 1'b1;
        end
        @(posedge clock);
        play_start <= 1'b0;
        wait_plays_done();
    endtask

    task automatic play_all();
        for (int i = 0; i < buf_depth; i++) begin
            play_word(addr_t'(i), 1'b0);
        end
    endtask

    // model update happens only once the scaler reports completion
    task automatic run_scale(input logic [group_w-1:0] grp, input sample_t gain,
                             input bit again);
        addr_t idx;
        @(posedge clock);
        scale_start <= 1'b1;
        scale_group <= grp;
        scale_gain <= gain;
        if (again) begin
            // second start lands while busy and must change nothing
            @(posedge clock);
            scale_group <= grp + 1'b1;
            scale_gain <= ~gain;
        end
        @(posedge clock);
        scale_start <= 1'b0;
        wait_scale_idle();
        for (int b = 0; b < group_size; b++) begin
            idx = addr_t'(grp * group_size + b);
            ref_mem[idx] = q15_scale(ref_mem[idx], gain);
        end
    endtask

    // compare each pulse against the oldest accepted play
    always @(negedge clock) begin : check_pulse
        sample_t expected;
        if (!fft_reset && audio_valid) begin
            if (exp_q.size() == 0) begin
                $display("audio_valid pulsed in test %s with no play outstanding", test_name);
                errors++;
            end else begin
                expected = exp_q.pop_front();
                check_value("audio_out", expected, audio_out);
            end
            pulses_seen++;
        end
    end

    initial begin
        logic [group_w-1:0] grp;
        sample_t            gain;
        void'($urandom(83657));
        fft_reset <= 1'b1;
        adc_ready <= 1'b0;
        adc_sample <= '0;
        scale_start <= 1'b0;
        scale_group <= '0;
        scale_gain <= '0;
        play_start <= 1'b0;
        play_index <= '0;
        repeat (8) @(posedge clock);
        fft_reset <= 1'b0;

        test_name = "idle_after_reset";
        repeat (20) begin
            @(negedge clock);
            check_value("scale_busy", 32'd0, scale_busy);
            check_value("play_busy", 32'd0, play_busy);
            check_value("audio_valid", 32'd0, audio_valid);
        end

        test_name = "capture_full";
        repeat (buf_depth) capture_sample(sample_t'($urandom()));
        play_all();

        // six more bring the count to 70, only indices 0..5 are rewritten
        test_name = "capture_wrap";
        repeat (6) capture_sample(sample_t'($urandom()));
        play_all();

        test_name = "scale_group";
        grp = group_w'($urandom());
        gain = sample_t'($urandom());
        run_scale(grp, gain, 1'b0);
        play_all();

        // captures land on 6..17, group 10 covers 40..43, play reads 50
        test_name = "contention";
        gain = sample_t'($urandom());
        fork
            repeat (12) capture_sample(sample_t'($urandom()));
            begin
                @(posedge clock);
                run_scale(4'd10, gain, 1'b0);
            end
            begin
                repeat (2) @(posedge clock);
                play_word(6'd50, 1'b0);
            end
        join
        play_all();

        test_name = "start_while_busy";
        grp = group_w'($urandom());
        gain = sample_t'($urandom());
        run_scale(grp, gain, 1'b1);
        play_word(addr_t'($urandom()), 1'b1);
        // a stray second pulse would show up in this window
        repeat (10) @(negedge clock);
        check_value("pulse count", plays_accepted, pulses_seen);
        play_all();

        finish_run();
    end

endmodule

`default_nettype wire

//--- all.f
hdl/spectral_pkg.sv
hdl/buffer_bus_pkg.sv
hdl/sample_capture.sv
hdl/bin_scaler.sv
hdl/audio_player.sv
hdl/buffer_arbiter.sv
hdl/spectral_buffer_top.sv
dv/tb_spectral_buffer.sv
